/* include/mdu_consts.svh */
`ifndef MDU_CONSTS_SVH
`define MDU_CONSTS_SVH

// issue queue geometry
`define MDU_IQ_DEPTH 8
`define MDU_IQ_IDX_W 4      // tail runs 0..depth, one bit wider than a slot index

// physical register file
`define MDU_PRF_NUM  64
`define MDU_TAG_W    6

// unit latencies, issue to wakeup
`define MDU_MUL_LAT  3
`define MDU_DIV_LAT  8

`endif

/* logic/mdu_pkg.sv */
`include "mdu_consts.svh"

package mdu_pkg;

    // physical register tag
    typedef logic [`MDU_TAG_W-1:0] prf_tag_t;

    // top bit set means divide
    typedef enum logic [1:0] {
        op_mul  = 2'b00,
        op_mulu = 2'b01,
        op_div  = 2'b10,
        op_divu = 2'b11
    } mdu_op_e;

    typedef enum logic {
        div_idle = 1'b0,
        div_run  = 1'b1
    } div_state_e;

endpackage

/* logic/mdu_busy_table.sv */
`timescale 1ns/1ps
`include "mdu_consts.svh"

module mdu_busy_table (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    set_en,
    input  mdu_pkg::prf_tag_t       set_tag,
    input  logic                    clr0_en,
    input  mdu_pkg::prf_tag_t       clr0_tag,
    input  logic                    clr1_en,
    input  mdu_pkg::prf_tag_t       clr1_tag,
    output logic [`MDU_PRF_NUM-1:0] busy_vec
);

    // later assignments win, so the set overrides a same-tag clear
    always_ff @(posedge clk) begin
        if (rst) begin
            busy_vec <= '0;
        end else begin
            if (clr0_en) begin
                busy_vec[clr0_tag] <= 1'b0;     // external producers
            end
            if (clr1_en) begin
                busy_vec[clr1_tag] <= 1'b0;     // mdu wakeup
            end
            if (set_en) begin
                busy_vec[set_tag] <= 1'b1;
            end
        end
    end

endmodule

/* logic/mdu_iq_entry.sv */
`timescale 1ns/1ps
`include "mdu_consts.svh"

module mdu_iq_entry (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    flush,
    input  logic                    load_en,
    input  logic                    shift_en,
    input  mdu_pkg::mdu_op_e        new_op,
    input  mdu_pkg::prf_tag_t       new_src0,
    input  mdu_pkg::prf_tag_t       new_src1,
    input  mdu_pkg::prf_tag_t       new_dst,
    input  logic                    new_rdy0,
    input  logic                    new_rdy1,
    input  mdu_pkg::mdu_op_e        up_op,
    input  mdu_pkg::prf_tag_t       up_src0,
    input  mdu_pkg::prf_tag_t       up_src1,
    input  mdu_pkg::prf_tag_t       up_dst,
    input  logic                    up_vld,
    input  logic [`MDU_PRF_NUM-1:0] busy_vec,
    output logic                    vld,
    output logic                    rdy,
    output logic                    is_div,
    output mdu_pkg::mdu_op_e        op,
    output mdu_pkg::prf_tag_t       src0,
    output mdu_pkg::prf_tag_t       src1,
    output mdu_pkg::prf_tag_t       dst
);
    import mdu_pkg::*;

    logic     rdy0_q;
    logic     rdy1_q;
    prf_tag_t nxt_src0;
    prf_tag_t nxt_src1;

    // sources this slot will hold after the edge
    assign nxt_src0 = shift_en ? up_src0 : src0;
    assign nxt_src1 = shift_en ? up_src1 : src1;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            vld <= 1'b0;
        end else if (load_en) begin
            vld <= 1'b1;
        end else if (shift_en) begin
            vld <= up_vld;
        end
    end

    always_ff @(posedge clk) begin
        if (load_en) begin
            op   <= new_op;
            src0 <= new_src0;
            src1 <= new_src1;
            dst  <= new_dst;
        end else if (shift_en) begin
            op   <= up_op;
            src0 <= up_src0;
            src1 <= up_src1;
            dst  <= up_dst;
        end
    end

    // readiness tracks the busy table one cycle behind
    always_ff @(posedge clk) begin
        rdy0_q <= load_en ? new_rdy0 : ~busy_vec[nxt_src0];
        rdy1_q <= load_en ? new_rdy1 : ~busy_vec[nxt_src1];
    end

    assign rdy    = vld & rdy0_q & rdy1_q;
    assign is_div = op[1];

endmodule

/* logic/mdu_issue_queue.sv */
`timescale 1ns/1ps
`include "mdu_consts.svh"

module mdu_issue_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     flush,
    input  logic                     enq,
    input  mdu_pkg::mdu_op_e         enq_op,
    input  mdu_pkg::prf_tag_t        enq_src0,
    input  mdu_pkg::prf_tag_t        enq_src1,
    input  mdu_pkg::prf_tag_t        enq_dst,
    input  logic [`MDU_PRF_NUM-1:0]  busy_vec,
    input  logic                     deq_valid,
    input  logic [`MDU_IQ_IDX_W-2:0] deq_idx,
    output logic                     full,
    output logic [`MDU_IQ_DEPTH-1:0] slot_vld,
    output logic [`MDU_IQ_DEPTH-1:0] slot_rdy,
    output logic [`MDU_IQ_DEPTH-1:0] slot_is_div,
    output mdu_pkg::mdu_op_e         issue_op,
    output mdu_pkg::prf_tag_t        issue_src0,
    output mdu_pkg::prf_tag_t        issue_src1,
    output mdu_pkg::prf_tag_t        issue_dst
);
    import mdu_pkg::*;

    localparam int SEL_W = `MDU_IQ_IDX_W - 1;

    logic [`MDU_IQ_IDX_W-1:0] tail;
    logic [`MDU_IQ_IDX_W-1:0] wr_idx;
    logic                     enq_ok;
    logic                     new_rdy0;
    logic                     new_rdy1;
    logic [`MDU_IQ_DEPTH:0]   vld_ext;
    mdu_op_e                  op_arr   [`MDU_IQ_DEPTH+1];
    prf_tag_t                 src0_arr [`MDU_IQ_DEPTH+1];
    prf_tag_t                 src1_arr [`MDU_IQ_DEPTH+1];
    prf_tag_t                 dst_arr  [`MDU_IQ_DEPTH+1];

    assign full   = (tail == `MDU_IQ_IDX_W'(`MDU_IQ_DEPTH));
    assign enq_ok = enq & ~full;
    assign wr_idx = tail - `MDU_IQ_IDX_W'(deq_valid);   // tail moves down when an op leaves

    assign new_rdy0 = ~busy_vec[enq_src0];
    assign new_rdy1 = ~busy_vec[enq_src1];

    // empty pseudo-slot above the top one
    assign vld_ext                 = {1'b0, slot_vld};
    assign op_arr[`MDU_IQ_DEPTH]   = op_mul;
    assign src0_arr[`MDU_IQ_DEPTH] = '0;
    assign src1_arr[`MDU_IQ_DEPTH] = '0;
    assign dst_arr[`MDU_IQ_DEPTH]  = '0;

    for (genvar i = 0; i < `MDU_IQ_DEPTH; i++) begin : g_slot
        mdu_iq_entry u_entry (
            .clk      (clk),
            .rst      (rst),
            .flush    (flush),
            .load_en  (enq_ok && (wr_idx == `MDU_IQ_IDX_W'(i))),
            .shift_en (deq_valid && (deq_idx <= SEL_W'(i))),
            .new_op   (enq_op),
            .new_src0 (enq_src0),
            .new_src1 (enq_src1),
            .new_dst  (enq_dst),
            .new_rdy0 (new_rdy0),
            .new_rdy1 (new_rdy1),
            .up_op    (op_arr[i+1]),
            .up_src0  (src0_arr[i+1]),
            .up_src1  (src1_arr[i+1]),
            .up_dst   (dst_arr[i+1]),
            .up_vld   (vld_ext[i+1]),
            .busy_vec (busy_vec),
            .vld      (slot_vld[i]),
            .rdy      (slot_rdy[i]),
            .is_div   (slot_is_div[i]),
            .op       (op_arr[i]),
            .src0     (src0_arr[i]),
            .src1     (src1_arr[i]),
            .dst      (dst_arr[i])
        );
    end

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            tail <= '0;
        end else begin
            tail <= tail + `MDU_IQ_IDX_W'(enq_ok) - `MDU_IQ_IDX_W'(deq_valid);
        end
    end

    assign issue_op   = op_arr[deq_idx];
    assign issue_src0 = src0_arr[deq_idx];
    assign issue_src1 = src1_arr[deq_idx];
    assign issue_dst  = dst_arr[deq_idx];

endmodule

/* logic/mdu_issue_select.sv */
`timescale 1ns/1ps
`include "mdu_consts.svh"

module mdu_issue_select (
    input  logic [`MDU_IQ_DEPTH-1:0] slot_rdy,
    input  logic [`MDU_IQ_DEPTH-1:0] slot_vld,
    input  logic [`MDU_IQ_DEPTH-1:0] slot_is_div,
    input  logic                     mul_busy,
    input  logic                     div_busy,
    output logic [`MDU_IQ_IDX_W-2:0] sel_idx,
    output logic                     sel_valid
);

    localparam int SEL_W = `MDU_IQ_IDX_W - 1;

    logic [`MDU_IQ_DEPTH-1:0] cand;

    assign cand = slot_rdy & slot_vld
                & ~(slot_is_div & {`MDU_IQ_DEPTH{div_busy}})
                & ~(~slot_is_div & {`MDU_IQ_DEPTH{mul_busy}});

    // scan from the top so the lowest slot, the oldest, wins
    always_comb begin
        sel_idx   = '0;
        sel_valid = 1'b0;
        for (int i = `MDU_IQ_DEPTH - 1; i >= 0; i--) begin
            if (cand[i]) begin
                sel_idx   = SEL_W'(i);
                sel_valid = 1'b1;
            end
        end
    end

endmodule

/* logic/mdu_fu_timer.sv */
`timescale 1ns/1ps
`include "mdu_consts.svh"

module mdu_fu_timer (
    input  logic              clk,
    input  logic              rst,
    input  logic              issue_valid,
    input  mdu_pkg::mdu_op_e  issue_op,
    input  mdu_pkg::prf_tag_t issue_dst,
    output logic              mul_busy,
    output logic              div_busy,
    output logic              wb_valid,
    output mdu_pkg::prf_tag_t wb_dst
);
    import mdu_pkg::*;

    localparam int DIV_CNT_W = $clog2(`MDU_DIV_LAT);

    logic                    mul_issue;
    logic                    div_issue;
    logic                    div_done;
    logic [`MDU_MUL_LAT-1:0] mul_vld;
    prf_tag_t                mul_dst [`MDU_MUL_LAT];
    div_state_e              div_state;
    logic [DIV_CNT_W-1:0]    div_cnt;
    prf_tag_t                div_dst;

    assign mul_issue = issue_valid && (issue_op inside {op_mul, op_mulu});
    assign div_issue = issue_valid && (issue_op inside {op_div, op_divu});

    // multiplier pipe, stage k is k+1 cycles after issue
    always_ff @(posedge clk) begin
        if (rst) begin
            mul_vld <= '0;
        end else begin
            mul_vld <= {mul_vld[`MDU_MUL_LAT-2:0], mul_issue};
        end
    end

    always_ff @(posedge clk) begin
        mul_dst[0] <= issue_dst;
        for (int i = 1; i < `MDU_MUL_LAT; i++) begin
            mul_dst[i] <= mul_dst[i-1];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            div_state <= div_idle;
            div_cnt   <= '0;
        end else begin
            case (div_state)
                div_idle: begin
                    if (div_issue) begin
                        div_state <= div_run;
                        div_cnt   <= DIV_CNT_W'(`MDU_DIV_LAT - 1);
                    end
                end
                div_run: begin
                    if (div_cnt == '0) begin
                        div_state <= div_idle;      // wakeup cycle
                    end else begin
                        div_cnt <= div_cnt - DIV_CNT_W'(1);
                    end
                end
                default: div_state <= div_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (div_issue) begin
            div_dst <= issue_dst;
        end
    end

    assign div_done = (div_state == div_run) && (div_cnt == '0);
    assign div_busy = (div_state == div_run);
    // a mul issued now would land on the divide's wakeup cycle
    assign mul_busy = div_busy && (div_cnt == DIV_CNT_W'(`MDU_MUL_LAT));

    assign wb_valid = div_done | mul_vld[`MDU_MUL_LAT-1];
    assign wb_dst   = div_done ? div_dst : mul_dst[`MDU_MUL_LAT-1];

endmodule

/* logic/mdu_issue_top.sv */
`timescale 1ns/1ps
`include "mdu_consts.svh"

module mdu_issue_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              flush,
    input  logic              enq,
    input  mdu_pkg::mdu_op_e  enq_op,
    input  mdu_pkg::prf_tag_t enq_src0,
    input  mdu_pkg::prf_tag_t enq_src1,
    input  mdu_pkg::prf_tag_t enq_dst,
    input  logic              ext_wb_valid,
    input  mdu_pkg::prf_tag_t ext_wb_dst,
    output logic              full,
    output logic              issue_valid,
    output mdu_pkg::mdu_op_e  issue_op,
    output mdu_pkg::prf_tag_t issue_src0,
    output mdu_pkg::prf_tag_t issue_src1,
    output mdu_pkg::prf_tag_t issue_dst,
    output logic              wb_valid,
    output mdu_pkg::prf_tag_t wb_dst
);

    logic [`MDU_PRF_NUM-1:0]  busy_vec;
    logic [`MDU_IQ_DEPTH-1:0] slot_vld;
    logic [`MDU_IQ_DEPTH-1:0] slot_rdy;
    logic [`MDU_IQ_DEPTH-1:0] slot_is_div;
    logic [`MDU_IQ_IDX_W-2:0] sel_idx;
    logic                     mul_busy;
    logic                     div_busy;

    mdu_busy_table u_busy (
        .clk      (clk),
        .rst      (rst),
        .set_en   (enq),
        .set_tag  (enq_dst),
        .clr0_en  (ext_wb_valid),
        .clr0_tag (ext_wb_dst),
        .clr1_en  (wb_valid),
        .clr1_tag (wb_dst),
        .busy_vec (busy_vec)
    );

    mdu_issue_queue u_iq (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .enq         (enq),
        .enq_op      (enq_op),
        .enq_src0    (enq_src0),
        .enq_src1    (enq_src1),
        .enq_dst     (enq_dst),
        .busy_vec    (busy_vec),
        .deq_valid   (issue_valid),
        .deq_idx     (sel_idx),
        .full        (full),
        .slot_vld    (slot_vld),
        .slot_rdy    (slot_rdy),
        .slot_is_div (slot_is_div),
        .issue_op    (issue_op),
        .issue_src0  (issue_src0),
        .issue_src1  (issue_src1),
        .issue_dst   (issue_dst)
    );

    mdu_issue_select u_sel (
        .slot_rdy    (slot_rdy),
        .slot_vld    (slot_vld),
        .slot_is_div (slot_is_div),
        .mul_busy    (mul_busy),
        .div_busy    (div_busy),
        .sel_idx     (sel_idx),
        .sel_valid   (issue_valid)
    );

    mdu_fu_timer u_fu (
        .clk         (clk),
        .rst         (rst),
        .issue_valid (issue_valid),
        .issue_op    (issue_op),
        .issue_dst   (issue_dst),
        .mul_busy    (mul_busy),
        .div_busy    (div_busy),
        .wb_valid    (wb_valid),
        .wb_dst      (wb_dst)
    );

endmodule

/* verif/mdu_tb_clk.sv */
`timescale 1ns/1ps

module mdu_tb_clk (
    output logic clk
);

    localparam int HALF_PERIOD = 50;    // 100 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

/* verif/mdu_tb.sv */
`timescale 1ns/1ps
`include "mdu_consts.svh"

module mdu_tb;
    import mdu_pkg::*;

    localparam int RST_CYCLES = 4;
    localparam int PAT_WORDS  = 1024;
    localparam int STIM_W     = 9;      // words per stimulus line
    localparam int ISSUE_W    = 4;      // words per expected issue

    logic       clk;
    logic       rst;
    logic       flush;
    logic       enq;
    mdu_op_e    enq_op;
    prf_tag_t   enq_src0;
    prf_tag_t   enq_src1;
    prf_tag_t   enq_dst;
    logic       ext_wb_valid;
    prf_tag_t   ext_wb_dst;
    logic       full;
    logic       issue_valid;
    mdu_op_e    issue_op;
    prf_tag_t   issue_src0;
    prf_tag_t   issue_src1;
    prf_tag_t   issue_dst;
    logic       wb_valid;
    prf_tag_t   wb_dst;

    logic [7:0] pat [PAT_WORDS];
    int         n_lines    = 0;
    int         n_issue    = 0;
    int         n_wb       = 0;
    int         issue_base = 0;
    int         wb_base    = 0;
    int         issue_seen = 0;
    int         wb_seen    = 0;
    int         wd_cycles  = 0;
    int         cycle_cnt  = 0;
    int         q_cnt      = 0;
    int         issue_cyc [`MDU_PRF_NUM] = '{default: -1};
    int         issue_lat [`MDU_PRF_NUM];

    mdu_tb_clk u_clk (
        .clk (clk)
    );

    mdu_issue_top u_dut (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .enq          (enq),
        .enq_op       (enq_op),
        .enq_src0     (enq_src0),
        .enq_src1     (enq_src1),
        .enq_dst      (enq_dst),
        .ext_wb_valid (ext_wb_valid),
        .ext_wb_dst   (ext_wb_dst),
        .full         (full),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_src0   (issue_src0),
        .issue_src1   (issue_src1),
        .issue_dst    (issue_dst),
        .wb_valid     (wb_valid),
        .wb_dst       (wb_dst)
    );

    task automatic abort_run();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string sig, input int exp_val, input int got_val);
        $display("FAILED at %0t: %s expected %0d, observed %0d", $time, sig, exp_val, got_val);
        abort_run();
    endtask

    task automatic check_issue(input mdu_op_e exp_op, input prf_tag_t exp_src0,
                               input prf_tag_t exp_src1, input prf_tag_t exp_dst);
        if (issue_op !== exp_op) begin
            report_mismatch("issue_op", int'(exp_op), int'(issue_op));
        end else if (issue_src0 !== exp_src0) begin
            report_mismatch("issue_src0", int'(exp_src0), int'(issue_src0));
        end else if (issue_src1 !== exp_src1) begin
            report_mismatch("issue_src1", int'(exp_src1), int'(issue_src1));
        end else if (issue_dst !== exp_dst) begin
            report_mismatch("issue_dst", int'(exp_dst), int'(issue_dst));
        end
    endtask

    task automatic check_wb(input prf_tag_t exp_dst, input int exp_cyc);
        if (wb_dst !== exp_dst) begin
            report_mismatch("wb_dst", int'(exp_dst), int'(wb_dst));
        end else if (cycle_cnt != exp_cyc) begin
            report_mismatch("wb_valid cycle", exp_cyc, cycle_cnt);
        end
    endtask

    task automatic check_full(input logic exp_full);
        if (full !== exp_full) begin
            report_mismatch("full", int'(exp_full), int'(full));
        end
    endtask

    task automatic load_patterns();
        int stim_cycles;
        $readmemh("verif/mdu_patterns.txt", pat);
        n_lines     = int'(pat[0]);
        n_issue     = int'(pat[1]);
        n_wb        = int'(pat[2]);
        issue_base  = 3 + n_lines * STIM_W;
        wb_base     = issue_base + n_issue * ISSUE_W;
        stim_cycles = 0;
        for (int ln = 0; ln < n_lines; ln++) begin
            stim_cycles += int'(pat[3 + ln * STIM_W]);  // hold count
        end
        wd_cycles = RST_CYCLES + stim_cycles + `MDU_DIV_LAT * `MDU_IQ_DEPTH;
    endtask

    task automatic drive_line(input int base);
        enq          <= pat[base + 1][0];
        enq_op       <= mdu_op_e'(pat[base + 2][1:0]);
        enq_src0     <= pat[base + 3][5:0];
        enq_src1     <= pat[base + 4][5:0];
        enq_dst      <= pat[base + 5][5:0];
        ext_wb_valid <= pat[base + 6][0];
        ext_wb_dst   <= pat[base + 7][5:0];
        flush        <= pat[base + 8][0];
    endtask

    initial begin
        int base;
        rst          = 1'b1;
        flush        = 1'b0;
        enq          = 1'b0;
        enq_op       = op_mul;
        enq_src0     = '0;
        enq_src1     = '0;
        enq_dst      = '0;
        ext_wb_valid = 1'b0;
        ext_wb_dst   = '0;
        load_patterns();
        if (n_lines == 0 || n_issue == 0 || n_wb == 0 || wb_base + n_wb > PAT_WORDS) begin
            $display("pattern file verif/mdu_patterns.txt is missing or its header is bad");
            abort_run();
        end
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        for (int ln = 0; ln < n_lines; ln++) begin
            base = 3 + ln * STIM_W;
            for (int k = 0; k < int'(pat[base]); k++) begin
                drive_line(base);
                @(posedge clk);
            end
        end
        enq          <= 1'b0;
        flush        <= 1'b0;
        ext_wb_valid <= 1'b0;
        wait (issue_seen == n_issue && wb_seen == n_wb);
        repeat (2 * `MDU_DIV_LAT) @(posedge clk);     // catch stray events
        $display("TB PASSED");
        $finish;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    // outputs sampled mid-cycle
    always @(negedge clk) begin
        int       b;
        prf_tag_t d;
        if (!rst && issue_valid) begin
            if (issue_seen >= n_issue) begin
                $display("unexpected issue of dst %0d at %0t beyond the expected list",
                         issue_dst, $time);
                abort_run();
            end else begin
                b = issue_base + issue_seen * ISSUE_W;
                d = pat[b + 3][5:0];
                issue_seen++;
                check_issue(mdu_op_e'(pat[b][1:0]), pat[b + 1][5:0], pat[b + 2][5:0], d);
                issue_cyc[d] = cycle_cnt;
                issue_lat[d] = pat[b][1] ? `MDU_DIV_LAT : `MDU_MUL_LAT;    // top op bit is divide
            end
        end
    end

    always @(negedge clk) begin
        prf_tag_t d;
        if (!rst && wb_valid) begin
            if (wb_seen >= n_wb) begin
                $display("unexpected wakeup of dst %0d at %0t beyond the expected list",
                         wb_dst, $time);
                abort_run();
            end else begin
                d = pat[wb_base + wb_seen][5:0];
                wb_seen++;
                check_wb(d, issue_cyc[d] + issue_lat[d]);
            end
        end
    end

    // queue occupancy, full at depth
    always @(negedge clk) begin
        logic exp_full;
        if (rst) begin
            q_cnt = 0;
        end else begin
            exp_full = (q_cnt == `MDU_IQ_DEPTH);
            check_full(exp_full);
            if (flush) begin
                q_cnt = 0;
            end else begin
                q_cnt = q_cnt + int'(enq && !exp_full) - int'(issue_valid);
            end
        end
    end

    initial begin
        wait (wd_cycles > 0);
        repeat (wd_cycles) @(posedge clk);
        $display("timeout after %0d cycles, issues or wakeups are missing", wd_cycles);
        $display("seen %0d of %0d issues and %0d of %0d wakeups",
                 issue_seen, n_issue, wb_seen, n_wb);
        abort_run();
    end

endmodule

/* project.f */
+incdir+include
logic/mdu_pkg.sv
logic/mdu_busy_table.sv
logic/mdu_iq_entry.sv
logic/mdu_issue_queue.sv
logic/mdu_issue_select.sv
logic/mdu_fu_timer.sv
logic/mdu_issue_top.sv
verif/mdu_tb_clk.sv
verif/mdu_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the MDU issue testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module mdu_tb -Mdir obj_dir -f project.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vmdu_tb > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

grep -q "^TB PASSED$" sim.log
if [ $? -ne 0 ]; then
    echo "pass message not found in sim.log"
    exit 1
fi

echo "simulation passed"
exit 0

/* verif/mdu_patterns.txt */
// header: stimulus line count, expected issue count, expected wakeup count
// stimulus: hold_cycles enq op src0 src1 dst ext_wb_valid ext_wb_dst flush
1c 10 10
// free sources, then a second divide behind the first
1 1 0 01 02 0a 0 00 0
1 1 1 03 04 0b 0 00 0
1 1 2 05 06 0c 0 00 0
1 1 3 07 08 0d 0 00 0
1 1 0 01 03 0e 0 00 0
1 1 0 02 04 0f 0 00 0
1 0 0 00 00 00 0 00 0
1 1 0 05 07 10 0 00 0
5 0 0 00 00 00 0 00 0
// blocked ops flushed, then one op after the flush
1 1 2 01 02 14 0 00 0
1 1 0 14 03 15 0 00 0
1 0 0 00 00 00 0 00 1
1 1 1 04 05 16 0 00 0
6 0 0 00 00 00 0 00 0
// fill the queue behind tags 14 and 15, one enq while full
1 1 3 14 01 1e 0 00 0
1 1 0 15 02 1f 0 00 0
1 1 1 03 15 20 0 00 0
1 1 0 15 04 21 0 00 0
1 1 0 15 15 22 0 00 0
1 1 1 05 15 23 0 00 0
1 1 0 15 06 24 0 00 0
1 1 0 15 07 25 0 00 0
1 1 0 01 02 28 0 00 0
1 0 0 00 00 00 0 00 0
1 0 0 00 00 00 1 15 0
8 0 0 00 00 00 0 00 0
1 0 0 00 00 00 1 14 0
4 0 0 00 00 00 0 00 0
// expected issues: op src0 src1 dst
0 01 02 0a
1 03 04 0b
2 05 06 0c
0 01 03 0e
0 02 04 0f
0 05 07 10
3 07 08 0d
1 04 05 16
0 15 02 1f
1 03 15 20
0 15 04 21
0 15 15 22
1 05 15 23
0 15 06 24
0 15 07 25
3 14 01 1e
// expected wakeup dst tags
0a 0b 0e 0f 0c 10 0d 16
1f 20 21 22 23 24 25 1e
